// File: frontend_pkg.sv
// Shared front end types and constants; RV32I only, no compressed encodings, QUEUE_DEPTH >= 2
package frontend_pkg;

    // Widths with a meaning of their own
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [6:0]  opcode_t;

    // Queue sizing
    localparam int QUEUE_DEPTH = 8;
    localparam int PTR_W       = $clog2(QUEUE_DEPTH);

    // Count is one bit wider so a full queue is distinct from an empty one
    typedef logic [PTR_W-1:0] q_ptr_t;
    typedef logic [PTR_W:0]   q_cnt_t;

    // First fetch address out of reset
    localparam word_t RESET_PC = 32'h0000_1000;

    // Major opcodes that select an immediate format
    localparam opcode_t OPCODE_LOAD   = 7'b0000011;
    localparam opcode_t OPCODE_OP_IMM = 7'b0010011;
    localparam opcode_t OPCODE_AUIPC  = 7'b0010111;
    localparam opcode_t OPCODE_STORE  = 7'b0100011;
    localparam opcode_t OPCODE_LUI    = 7'b0110111;
    localparam opcode_t OPCODE_BRANCH = 7'b1100011;
    localparam opcode_t OPCODE_JALR   = 7'b1100111;
    localparam opcode_t OPCODE_JAL    = 7'b1101111;

    // One fetched instruction with its predicted successor, 96 bits
    typedef struct packed {
        word_t pc;
        word_t next_pc;
        word_t instr;
    } fq_entry_t;

    // Decoded fields handed to issue
    typedef struct packed {
        word_t    pc;
        word_t    next_pc;
        opcode_t  opcode;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        logic [2:0] funct3;
        logic [6:0] funct7;
        word_t    imm;
    } decoded_t;

endpackage

// File: fetch_stage.sv
// Fetch with a same-cycle combinational instruction memory; only JAL is predicted taken, PCs assumed word aligned
module fetch_stage
    import frontend_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  logic      flush,
    input  word_t     redirect_pc,
    input  logic      full,
    output word_t     imem_addr,
    input  word_t     imem_rdata,
    output logic      fq_wr,
    output fq_entry_t fq_wdata
);

    word_t pc;
    word_t pred_next_pc;
    word_t j_imm;
    logic  is_jal;

    // Memory is addressed straight from the PC register
    assign imem_addr = pc;

    // JAL predecode, target is known without any register read
    assign is_jal = (imem_rdata[6:0] == OPCODE_JAL);

    assign j_imm = {
        {11{imem_rdata[31]}},
        imem_rdata[31],
        imem_rdata[19:12],
        imem_rdata[20],
        imem_rdata[30:21],
        1'b0
    };

    // Everything else falls through to the next word
    assign pred_next_pc = is_jal ? (pc + j_imm) : (pc + 32'd4);

    // No write into a full queue, none while a redirect is in flight
    assign fq_wr = !full && !flush;

    always_comb begin
        fq_wdata.pc      = pc;
        fq_wdata.next_pc = pred_next_pc;
        fq_wdata.instr   = imem_rdata;
    end

    // PC only moves when its entry has been written, or on redirect
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= RESET_PC;
        end else if (flush) begin
            pc <= redirect_pc;
        end else if (!full) begin
            pc <= pred_next_pc;
        end
    end

endmodule

// File: i_queue.sv
// Instruction queue of QUEUE_DEPTH entries; head is only meaningful while empty is low, flush discards all entries
module i_queue
    import frontend_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  logic      flush,
    input  logic      write,
    input  fq_entry_t wdata,
    input  logic      read,
    output fq_entry_t head,
    output logic      empty,
    output logic      full
);

    fq_entry_t mem [QUEUE_DEPTH];

    q_ptr_t head_ptr;
    q_ptr_t tail_ptr;
    q_cnt_t count;

    logic do_rd;
    logic do_wr;

    // Wrap explicitly so a depth that is not a power of two still works
    function automatic q_ptr_t next_ptr(input q_ptr_t ptr);
        q_ptr_t nxt;
        if (ptr == q_ptr_t'(QUEUE_DEPTH - 1)) begin
            nxt = '0;
        end else begin
            nxt = ptr + 1'b1;
        end
        return nxt;
    endfunction

    assign empty = (count == '0);
    assign full  = (count == q_cnt_t'(QUEUE_DEPTH));

    // Oldest entry is always on the output
    assign head = mem[head_ptr];

    // Reads of an empty queue are dropped
    assign do_rd = read && !empty;

    // A write into a full queue only goes through when a slot frees this cycle
    assign do_wr = write && (!full || do_rd);

    // Storage
    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[tail_ptr] <= wdata;
        end
    end

    // Pointers and occupancy
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            count    <= '0;
        end else if (flush) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            count    <= '0;
        end else begin
            if (do_rd) begin
                head_ptr <= next_ptr(head_ptr);
            end
            if (do_wr) begin
                tail_ptr <= next_ptr(tail_ptr);
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: decode_stage.sv
// Single-entry decode register; R-type and unknown opcodes get a zero immediate, no illegal-instruction check
module decode_stage
    import frontend_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  logic      flush,
    input  logic      stall,
    input  logic      empty,
    input  fq_entry_t head,
    output logic      read,
    output logic      dec_valid,
    output decoded_t  dec_out
);

    word_t    instr;
    decoded_t dec_next;
    logic     accept;

    assign instr = head.instr;

    // Register is free, or its content leaves this cycle
    assign accept = !dec_valid || !stall;

    // Nothing is popped at a flush edge, the queue is cleared anyway
    assign read = !empty && accept && !flush;

    // Field extraction
    always_comb begin
        dec_next.pc      = head.pc;
        dec_next.next_pc = head.next_pc;
        dec_next.opcode  = instr[6:0];
        dec_next.rd      = instr[11:7];
        dec_next.funct3  = instr[14:12];
        dec_next.rs1     = instr[19:15];
        dec_next.rs2     = instr[24:20];
        dec_next.funct7  = instr[31:25];

        // Immediate format follows the major opcode
        case (instr[6:0])
            OPCODE_LOAD, OPCODE_OP_IMM, OPCODE_JALR: begin
                dec_next.imm = {{20{instr[31]}}, instr[31:20]};
            end
            OPCODE_STORE: begin
                dec_next.imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            OPCODE_BRANCH: begin
                dec_next.imm = {{19{instr[31]}}, instr[31], instr[7],
                                instr[30:25], instr[11:8], 1'b0};
            end
            OPCODE_LUI, OPCODE_AUIPC: begin
                dec_next.imm = {instr[31:12], 12'b0};
            end
            OPCODE_JAL: begin
                dec_next.imm = {{11{instr[31]}}, instr[31], instr[19:12],
                                instr[20], instr[30:21], 1'b0};
            end
            default: begin
                dec_next.imm = '0;
            end
        endcase
    end

    // Valid flag, drops once consumed unless a new entry replaces it
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dec_valid <= 1'b0;
        end else if (flush) begin
            dec_valid <= 1'b0;
        end else if (read) begin
            dec_valid <= 1'b1;
        end else if (!stall) begin
            dec_valid <= 1'b0;
        end
    end

    // Payload holds while stalled since no pop happens then
    always_ff @(posedge clk) begin
        if (read) begin
            dec_out <= dec_next;
        end
    end

endmodule

// File: frontend_top.sv
// Front end top: fetch, instruction queue and decode; instruction memory and branch resolution live outside
module frontend_top
    import frontend_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    output word_t    imem_addr,
    input  word_t    imem_rdata,
    input  logic     flush,
    input  word_t    redirect_pc,
    input  logic     stall,
    output logic     dec_valid,
    output decoded_t dec_out
);

    // Fetch to queue
    logic      fq_wr;
    fq_entry_t fq_wdata;
    logic      fq_full;

    // Queue to decode
    fq_entry_t fq_head;
    logic      fq_empty;
    logic      fq_rd;

    fetch_stage u_fetch (
        .clk         (clk),
        .arst_n      (arst_n),
        .flush       (flush),
        .redirect_pc (redirect_pc),
        .full        (fq_full),
        .imem_addr   (imem_addr),
        .imem_rdata  (imem_rdata),
        .fq_wr       (fq_wr),
        .fq_wdata    (fq_wdata)
    );

    i_queue u_queue (
        .clk    (clk),
        .arst_n (arst_n),
        .flush  (flush),
        .write  (fq_wr),
        .wdata  (fq_wdata),
        .read   (fq_rd),
        .head   (fq_head),
        .empty  (fq_empty),
        .full   (fq_full)
    );

    decode_stage u_decode (
        .clk       (clk),
        .arst_n    (arst_n),
        .flush     (flush),
        .stall     (stall),
        .empty     (fq_empty),
        .head      (fq_head),
        .read      (fq_rd),
        .dec_valid (dec_valid),
        .dec_out   (dec_out)
    );

endmodule

// File: frontend_checker.sv
// Front end scoreboard; memory contents come from mem_word, redirect PCs are assumed word aligned
module frontend_checker
    import frontend_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  logic     flush,
    input  word_t    redirect_pc,
    input  logic     stall,
    input  word_t    imem_addr,
    input  logic     dec_valid,
    input  decoded_t dec_out,
    output int       errors,
    output int       consumed
);
    timeunit 1ns;
    timeprecision 1ps;

    int       err_cnt      = 0;
    int       out_cnt      = 0;
    word_t    exp_pc       = RESET_PC;
    logic     hold_pending = 1'b0;
    decoded_t held;
    logic     addr_due     = 1'b0;
    word_t    addr_exp     = RESET_PC;

    assign errors   = err_cnt;
    assign consumed = out_cnt;

    // A hash of the full address picks the instruction encoding
    function automatic word_t mem_word(input word_t addr);
        word_t      h;
        logic [4:0] words;
        h = addr * 32'h9e37_79b1;
        h = h ^ (h >> 16);
        words = {1'b0, h[6:3]} + 5'd1;
        if (h[2:0] == 3'd0) begin
            // Forward JAL of 1 to 16 words
            return {1'b0, 4'b0000, words, 1'b0, 1'b0, 8'h00, h[11:7], OPCODE_JAL};
        end
        case (h[4:3])
            2'd0:    return {h[31:7], h[5] ? OPCODE_OP_IMM : 7'b0110011};
            2'd1:    return {h[31:7], OPCODE_LOAD};
            2'd2:    return {h[31:7], OPCODE_STORE};
            default: return {h[31:7], OPCODE_BRANCH};
        endcase
    endfunction

    // Arithmetic shifts supply the sign of each RV32I immediate format
    function automatic word_t ref_imm(input word_t instr);
        case (instr[6:0])
            OPCODE_OP_IMM, OPCODE_LOAD, OPCODE_JALR: return word_t'($signed(instr) >>> 20);
            OPCODE_STORE:
                return word_t'($signed({instr[31:25], instr[11:7], 20'h0}) >>> 20);
            OPCODE_BRANCH:
                return word_t'($signed({instr[31], instr[7], instr[30:25], instr[11:8],
                                        20'h0}) >>> 19);
            OPCODE_JAL:
                return word_t'($signed({instr[31], instr[19:12], instr[20], instr[30:21],
                                        12'h0}) >>> 11);
            OPCODE_LUI, OPCODE_AUIPC: return {instr[31:12], 12'h000};
            default: return '0;
        endcase
    endfunction

    function automatic word_t ref_next_pc(input word_t pc, input word_t instr);
        return (instr[6:0] == OPCODE_JAL) ? pc + ref_imm(instr) : pc + 32'd4;
    endfunction

    function automatic decoded_t ref_decode(input word_t pc, input word_t instr);
        decoded_t d;
        d.pc      = pc;
        d.next_pc = ref_next_pc(pc, instr);
        d.opcode  = instr[6:0];
        d.rd      = instr[11:7];
        d.rs1     = instr[19:15];
        d.rs2     = instr[24:20];
        d.funct3  = instr[14:12];
        d.funct7  = instr[31:25];
        d.imm     = ref_imm(instr);
        return d;
    endfunction

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (exp !== act) begin
            err_cnt++;
            $display("ERR %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_output(input word_t pc);
        decoded_t e;
        e = ref_decode(pc, mem_word(pc));
        check_word("stream_pc", e.pc, dec_out.pc);
        check_word("stream_next_pc", e.next_pc, dec_out.next_pc);
        check_word("decode_opcode", 32'(e.opcode), 32'(dec_out.opcode));
        check_word("decode_rd", 32'(e.rd), 32'(dec_out.rd));
        check_word("decode_rs1", 32'(e.rs1), 32'(dec_out.rs1));
        check_word("decode_rs2", 32'(e.rs2), 32'(dec_out.rs2));
        check_word("decode_funct3", 32'(e.funct3), 32'(dec_out.funct3));
        check_word("decode_funct7", 32'(e.funct7), 32'(dec_out.funct7));
        check_word("decode_imm", e.imm, dec_out.imm);
    endtask

    always @(posedge clk) begin
        if (!arst_n) begin
            exp_pc       = RESET_PC;
            hold_pending = 1'b0;
            // First fetch address once reset is released
            addr_due     = 1'b1;
            addr_exp     = RESET_PC;
            if (dec_valid) begin
                err_cnt++;
                $display("dec_valid was high while reset was asserted");
            end
        end else begin
            // Fetch address right after reset or a flush edge
            if (addr_due) begin
                check_word("fetch_addr", addr_exp, imem_addr);
            end
            // Output seen stalled at the last edge must still be there
            if (hold_pending && !dec_valid) begin
                err_cnt++;
                $display("dec_valid dropped while stall was high");
            end else if (hold_pending && (dec_out !== held)) begin
                err_cnt++;
                $display("ERR stall_hold expected %h actual %h", held, dec_out);
            end
            if (dec_valid && !stall) begin
                check_output(exp_pc);
                exp_pc = ref_next_pc(exp_pc, mem_word(exp_pc));
                out_cnt++;
            end
            // An output at the flush edge still counts before the redirect
            if (flush) begin
                exp_pc = redirect_pc;
            end
            hold_pending = dec_valid && stall && !flush;
            held         = dec_out;
            addr_due     = flush;
            addr_exp     = redirect_pc;
        end
    end

endmodule

// File: tb_frontend.sv
// Front end testbench; fixed-seed LFSR stimulus, instruction memory answers in the same cycle
module tb_frontend
    import frontend_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD    = 40;
    localparam int RESET_CYCLES  = 10;
    localparam int STREAM_CYCLES = 200;
    localparam int STALL_CYCLES  = 400;
    localparam int FLUSH_CYCLES  = 400;
    localparam int MIXED_CYCLES  = 300;
    localparam int DRAIN_OUTPUTS = 16;
    localparam int DRAIN_CYCLES  = 2 * DRAIN_OUTPUTS + QUEUE_DEPTH;
    localparam int TOTAL_CYCLES  = RESET_CYCLES + STREAM_CYCLES + STALL_CYCLES + FLUSH_CYCLES
                                   + MIXED_CYCLES + DRAIN_CYCLES;
    localparam int MARGIN_CYCLES = 20;
    localparam logic [31:0] LFSR_SEED = 32'h683a5686;
    // Maximal length polynomial x^32 + x^22 + x^2 + x + 1
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    logic        clk = 1'b0;
    logic        arst_n;
    logic        flush;
    word_t       redirect_pc;
    logic        stall;
    word_t       imem_addr;
    word_t       imem_rdata;
    logic        dec_valid;
    decoded_t    dec_out;
    int          errors;
    int          consumed;
    logic [31:0] lfsr_state = LFSR_SEED;

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Memory model shares its contents with the scoreboard
    assign imem_rdata = chk.mem_word(imem_addr);

    frontend_top dut (
        .clk         (clk),
        .arst_n      (arst_n),
        .imem_addr   (imem_addr),
        .imem_rdata  (imem_rdata),
        .flush       (flush),
        .redirect_pc (redirect_pc),
        .stall       (stall),
        .dec_valid   (dec_valid),
        .dec_out     (dec_out)
    );

    frontend_checker chk (
        .clk         (clk),
        .arst_n      (arst_n),
        .flush       (flush),
        .redirect_pc (redirect_pc),
        .stall       (stall),
        .imem_addr   (imem_addr),
        .dec_valid   (dec_valid),
        .dec_out     (dec_out),
        .errors      (errors),
        .consumed    (consumed)
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    // One LFSR step per bit
    task automatic take_bits(input int n, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits       = {bits[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic drive_cycle(input logic st, input logic fl, input word_t rpc);
        @(posedge clk);
        stall       <= st;
        flush       <= fl;
        redirect_pc <= rpc;
    endtask

    // Stall bursts longer than the queue make full rise and fetch hold
    task automatic stall_bursts(input int cycles);
        logic [31:0] r;
        logic        on;
        int          left;
        on   = 1'b0;
        left = 0;
        for (int c = 0; c < cycles; c++) begin
            if (left == 0) begin
                on = !on;
                take_bits(3, r);
                left = on ? QUEUE_DEPTH + 1 + int'(r[2:0]) : 1 + int'(r[2:0]);
            end
            drive_cycle(on, 1'b0, redirect_pc);
            left--;
        end
    endtask

    task automatic random_flushes(input int cycles, input logic with_stall);
        logic [31:0] r;
        logic [31:0] a;
        logic        fl;
        logic        st;
        for (int c = 0; c < cycles; c++) begin
            if (with_stall) begin
                // Flush about three cycles in eight to get back-to-back flushes
                take_bits(3, r);
                fl = (r[2:0] < 3'd3);
                take_bits(1, r);
                st = r[0];
            end else begin
                take_bits(4, r);
                fl = (r[3:0] == 4'd0);
                st = 1'b0;
            end
            take_bits(14, a);
            drive_cycle(st, fl, {16'h0000, a[13:0], 2'b00});
        end
    endtask

    task automatic drain_outputs();
        int target;
        @(negedge clk);
        target = consumed + DRAIN_OUTPUTS;
        drive_cycle(1'b0, 1'b0, redirect_pc);
        while (consumed < target) begin
            @(negedge clk);
        end
    endtask

    initial begin
        arst_n      = 1'b0;
        flush       = 1'b0;
        redirect_pc = RESET_PC;
        stall       = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;
        repeat (STREAM_CYCLES) drive_cycle(1'b0, 1'b0, RESET_PC);
        stall_bursts(STALL_CYCLES);
        random_flushes(FLUSH_CYCLES, 1'b0);
        random_flushes(MIXED_CYCLES, 1'b1);
        drain_outputs();
        @(negedge clk);
        $display("Decode outputs checked: %0d, errors: %0d", consumed, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin
        #((TOTAL_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        $display("Watchdog expired: the run did not finish within its cycle budget");
        $display("Simulation FAILED");
        $finish;
    end

endmodule

// File: verilog.f
frontend_pkg.sv
fetch_stage.sv
i_queue.sv
decode_stage.sv
frontend_top.sv
frontend_checker.sv
tb_frontend.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timescale 1ns/1ps -f verilog.f --top-module tb_frontend -o tb_frontend_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_frontend_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation run returned status $status"
    exit 1
fi

if grep -q "Simulation FAILED" "$LOG"; then
    exit 1
fi
exit 0
